/* source/matrix_gcd_pkg.sv */
// Matrix GCD shared types
// Data words, stage items and FSM states
`default_nettype none

package matrix_gcd_pkg;

  ////////////////////////////////////////////////////////////
  // Data sizing
  ////////////////////////////////////////////////////////////

  // Operand, result and modulus width
  localparam int data_width = 16;

  // Plain unsigned data word
  typedef logic [data_width-1:0] gcd_data_t;

  ////////////////////////////////////////////////////////////
  // Stream payloads
  ////////////////////////////////////////////////////////////

  // Operand pair in flight between sequencer and Euclid engine
  typedef struct packed {
    gcd_data_t operand_a;
    gcd_data_t operand_b;
    logic      row_end;
    logic      matrix_end;
  } gcd_item_t;

  // One result word plus its position flags
  typedef struct packed {
    gcd_data_t value;
    logic      row_end;
    logic      matrix_end;
  } gcd_result_t;

  ////////////////////////////////////////////////////////////
  // State encodings
  ////////////////////////////////////////////////////////////

  // Sequencer job state
  typedef enum logic [0:0] {
    seq_idle,
    seq_run
  } seq_state_e;

  // Shared by Euclid and modulo stages
  typedef enum logic [1:0] {
    stage_empty,
    stage_busy,
    stage_full
  } engine_state_e;

endpackage

`default_nettype wire

/* source/element_sequencer.sv */
// Element sequencer
`timescale 1ns/1ps
`default_nettype none

module element_sequencer #(
  parameter int index_width = 8
) (
  input  wire logic                             CLK,
  input  wire logic                             RST,
  input  wire logic                             start,
  input  wire logic [index_width-1:0]           size_rows,
  input  wire logic [index_width-1:0]           size_cols,
  input  wire logic                             in_valid,
  output logic                                  in_ready,
  input  wire matrix_gcd_pkg::gcd_data_t        in_a,
  input  wire matrix_gcd_pkg::gcd_data_t        in_b,
  input  wire logic                             job_done,
  output logic                                  busy,
  output logic                                  seq_valid,
  input  wire logic                             seq_ready,
  output matrix_gcd_pkg::gcd_item_t             seq_item
);

  matrix_gcd_pkg::seq_state_e state;

  // Effective sizes, zero counts as one
  logic [index_width-1:0] row_size;
  logic [index_width-1:0] col_size;
  logic [index_width-1:0] row_idx;
  logic [index_width-1:0] col_idx;

  // Last pair of the job already taken
  logic fed_all;
  logic start_ok;
  logic take;
  logic last_col;
  logic last_row;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  assign start_ok = start && (state == matrix_gcd_pkg::seq_idle);
  // Output register empty or being drained this cycle
  assign in_ready = (state == matrix_gcd_pkg::seq_run) && !fed_all &&
                    (!seq_valid || seq_ready);
  assign take     = in_valid && in_ready;
  assign last_col = (col_idx == col_size - 1'b1);
  assign last_row = (row_idx == row_size - 1'b1);
  assign busy     = (state == matrix_gcd_pkg::seq_run);

  ////////////////////////////////////////////////////////////
  // Job FSM and index walk
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= matrix_gcd_pkg::seq_idle;
      fed_all   <= 1'b0;
      row_idx   <= '0;
      col_idx   <= '0;
      seq_valid <= 1'b0;
    end else begin
      if (start_ok) begin
        state   <= matrix_gcd_pkg::seq_run;
        fed_all <= 1'b0;
        row_idx <= '0;
        col_idx <= '0;
      end else if (job_done) begin
        state <= matrix_gcd_pkg::seq_idle;
      end
      if (take) begin
        // Column first, then row
        if (last_col) begin
          col_idx <= '0;
          if (last_row) fed_all <= 1'b1;
          else row_idx <= row_idx + 1'b1;
        end else begin
          col_idx <= col_idx + 1'b1;
        end
        seq_valid <= 1'b1;
      end else if (seq_ready) begin
        seq_valid <= 1'b0;
      end
    end
  end

  // Sizes and payload
  always_ff @(posedge CLK) begin
    if (start_ok) begin
      row_size <= (size_rows == '0) ? index_width'(1) : size_rows;
      col_size <= (size_cols == '0) ? index_width'(1) : size_cols;
    end
    if (take) begin
      seq_item.operand_a  <= in_a;
      seq_item.operand_b  <= in_b;
      seq_item.row_end    <= last_col;
      seq_item.matrix_end <= last_col && last_row;
    end
  end

  // Column walk stays inside the latched width
  a_col_in_range: assert property (@(posedge CLK) disable iff (RST)
    (state == matrix_gcd_pkg::seq_run) |-> (col_idx < col_size));

endmodule

`default_nettype wire

/* source/euclid_engine.sv */
// Subtractive Euclid stage
`timescale 1ns/1ps
`default_nettype none

module euclid_engine (
  input  wire logic                        CLK,
  input  wire logic                        RST,
  input  wire logic                        seq_valid,
  output logic                             seq_ready,
  input  wire matrix_gcd_pkg::gcd_item_t   seq_item,
  output logic                             gcd_valid,
  input  wire logic                        gcd_ready,
  output matrix_gcd_pkg::gcd_result_t      gcd_item_out
);

  ////////////////////////////////////////////////////////////
  // Stage registers
  ////////////////////////////////////////////////////////////

  matrix_gcd_pkg::engine_state_e state;

  // Working operands, shrink toward the gcd
  matrix_gcd_pkg::gcd_data_t op_a;
  matrix_gcd_pkg::gcd_data_t op_b;

  // Flags ride along untouched
  logic row_end_q;
  logic matrix_end_q;

  logic load;
  logic either_zero;
  logic a_ge_b;

  assign load        = seq_valid && seq_ready;
  assign either_zero = (op_a == '0) || (op_b == '0);
  assign a_ge_b      = (op_a >= op_b);

  ////////////////////////////////////////////////////////////
  // Handshake and result
  ////////////////////////////////////////////////////////////

  // Takes a new pair only when fully empty
  assign seq_ready = (state == matrix_gcd_pkg::stage_empty);
  assign gcd_valid = (state == matrix_gcd_pkg::stage_full);

  // One operand is zero once done, so OR gives the other
  assign gcd_item_out.value      = op_a | op_b;
  assign gcd_item_out.row_end    = row_end_q;
  assign gcd_item_out.matrix_end = matrix_end_q;

  ////////////////////////////////////////////////////////////
  // Stage FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state <= matrix_gcd_pkg::stage_empty;
    end else begin
      case (state)
        matrix_gcd_pkg::stage_empty: begin
          if (load) state <= matrix_gcd_pkg::stage_busy;
        end
        matrix_gcd_pkg::stage_busy: begin
          // gcd(a, 0) = a, gcd(0, 0) = 0
          if (either_zero) state <= matrix_gcd_pkg::stage_full;
        end
        matrix_gcd_pkg::stage_full: begin
          if (gcd_ready) state <= matrix_gcd_pkg::stage_empty;
        end
        default: begin
          state <= matrix_gcd_pkg::stage_empty;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Operand datapath
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (load) begin
      op_a         <= seq_item.operand_a;
      op_b         <= seq_item.operand_b;
      row_end_q    <= seq_item.row_end;
      matrix_end_q <= seq_item.matrix_end;
    end else if ((state == matrix_gcd_pkg::stage_busy) && !either_zero) begin
      // Larger minus smaller, one step per cycle
      if (a_ge_b) op_a <= op_a - op_b;
      else op_b <= op_b - op_a;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // Subtract steps only ever shrink the operands
  a_no_growth: assert property (@(posedge CLK) disable iff (RST)
    (state == matrix_gcd_pkg::stage_busy) |=>
      ((op_a <= $past(op_a)) && (op_b <= $past(op_b))));

  // Result held steady under back-pressure
  a_hold_valid: assert property (@(posedge CLK) disable iff (RST)
    (gcd_valid && !gcd_ready) |=> (gcd_valid && $stable(gcd_item_out)));

endmodule

`default_nettype wire

/* source/modulo_reducer.sv */
// Restoring-division modulo stage
`timescale 1ns/1ps
`default_nettype none

module modulo_reducer (
  input  wire logic                          CLK,
  input  wire logic                          RST,
  input  wire matrix_gcd_pkg::gcd_data_t     modulus,
  input  wire logic                          gcd_valid,
  output logic                               gcd_ready,
  input  wire matrix_gcd_pkg::gcd_result_t   gcd_item_in,
  output logic                               out_valid,
  input  wire logic                          out_ready,
  output matrix_gcd_pkg::gcd_result_t        out_result
);

  localparam int dw        = matrix_gcd_pkg::data_width;
  localparam int cnt_width = $clog2(dw + 1);

  matrix_gcd_pkg::engine_state_e state;

  // Remainder doubles as the result word
  matrix_gcd_pkg::gcd_data_t rem;
  // Dividend shifts out MSB first, quotient bits shift in
  matrix_gcd_pkg::gcd_data_t dvd;
  logic [cnt_width-1:0]      bit_cnt;
  logic                      row_end_q;
  logic                      matrix_end_q;

  logic        load;
  logic        last_bit;
  logic [dw:0] trial;
  logic        q_bit;

  assign load      = gcd_valid && gcd_ready;
  assign gcd_ready = (state == matrix_gcd_pkg::stage_empty);
  assign out_valid = (state == matrix_gcd_pkg::stage_full);
  assign last_bit  = (bit_cnt == cnt_width'(dw - 1));

  // Partial remainder with next dividend bit
  assign trial = {rem, dvd[dw-1]};
  assign q_bit = (trial >= {1'b0, modulus});

  assign out_result.value      = rem;
  assign out_result.row_end    = row_end_q;
  assign out_result.matrix_end = matrix_end_q;

  ////////////////////////////////////////////////////////////
  // Stage FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= matrix_gcd_pkg::stage_empty;
      bit_cnt <= '0;
    end else begin
      case (state)
        matrix_gcd_pkg::stage_empty: begin
          bit_cnt <= '0;
          // Zero modulus skips the division
          if (load && (modulus == '0)) state <= matrix_gcd_pkg::stage_full;
          else if (load) state <= matrix_gcd_pkg::stage_busy;
        end
        matrix_gcd_pkg::stage_busy: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_bit) state <= matrix_gcd_pkg::stage_full;
        end
        matrix_gcd_pkg::stage_full: begin
          if (out_ready) state <= matrix_gcd_pkg::stage_empty;
        end
        default: begin
          state <= matrix_gcd_pkg::stage_empty;
        end
      endcase
    end
  end

  // Division datapath, one quotient bit per cycle
  always_ff @(posedge CLK) begin
    if (load) begin
      rem          <= (modulus == '0) ? gcd_item_in.value : '0;
      dvd          <= gcd_item_in.value;
      row_end_q    <= gcd_item_in.row_end;
      matrix_end_q <= gcd_item_in.matrix_end;
    end else if (state == matrix_gcd_pkg::stage_busy) begin
      rem <= q_bit ? dw'(trial - {1'b0, modulus}) : trial[dw-1:0];
      dvd <= {dvd[dw-2:0], q_bit};
    end
  end

  // Reduced value always below a nonzero modulus
  a_rem_below_mod: assert property (@(posedge CLK) disable iff (RST)
    (out_valid && (modulus != '0)) |-> (out_result.value < modulus));

endmodule

`default_nettype wire

/* source/matrix_gcd_top.sv */
// Matrix GCD pipeline top
`timescale 1ns/1ps
`default_nettype none

module matrix_gcd_top #(
  parameter int index_width = 8
) (
  input  wire logic                          CLK,
  input  wire logic                          RST,
  input  wire logic                          start,
  input  wire logic [index_width-1:0]        size_rows,
  input  wire logic [index_width-1:0]        size_cols,
  input  wire matrix_gcd_pkg::gcd_data_t     modulus,
  input  wire logic                          in_valid,
  output logic                               in_ready,
  input  wire matrix_gcd_pkg::gcd_data_t     in_a,
  input  wire matrix_gcd_pkg::gcd_data_t     in_b,
  output logic                               busy,
  output logic                               out_valid,
  input  wire logic                          out_ready,
  output matrix_gcd_pkg::gcd_result_t        out_result
);

  ////////////////////////////////////////////////////////////
  // Job registers
  ////////////////////////////////////////////////////////////

  matrix_gcd_pkg::gcd_data_t   modulus_q;
  logic                        job_done;

  // Inter-stage streams
  logic                        seq_valid;
  logic                        seq_ready;
  matrix_gcd_pkg::gcd_item_t   seq_item;
  logic                        gcd_valid;
  logic                        gcd_ready;
  matrix_gcd_pkg::gcd_result_t gcd_item;

  // Modulus held for the whole job
  always_ff @(posedge CLK) begin
    if (start && !busy) modulus_q <= modulus;
  end

  // Last result leaves the output
  assign job_done = out_valid && out_ready && out_result.matrix_end;

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////

  element_sequencer #(
    .index_width(index_width)
  ) u_sequencer (
    .CLK(CLK), .RST(RST),
    .start(start), .size_rows(size_rows), .size_cols(size_cols),
    .in_valid(in_valid), .in_ready(in_ready), .in_a(in_a), .in_b(in_b),
    .job_done(job_done), .busy(busy),
    .seq_valid(seq_valid), .seq_ready(seq_ready), .seq_item(seq_item)
  );

  euclid_engine u_euclid (
    .CLK(CLK), .RST(RST),
    .seq_valid(seq_valid), .seq_ready(seq_ready), .seq_item(seq_item),
    .gcd_valid(gcd_valid), .gcd_ready(gcd_ready), .gcd_item_out(gcd_item)
  );

  modulo_reducer u_modulo (
    .CLK(CLK), .RST(RST), .modulus(modulus_q),
    .gcd_valid(gcd_valid), .gcd_ready(gcd_ready), .gcd_item_in(gcd_item),
    .out_valid(out_valid), .out_ready(out_ready), .out_result(out_result)
  );

endmodule

`default_nettype wire

/* bench/matrix_gcd_tb.sv */
// Matrix GCD testbench
// Golden-file stimulus with random stalls
`timescale 1ns/1ps
`default_nettype none

module matrix_gcd_tb;

  localparam int index_width = 8;
  localparam int dw          = matrix_gcd_pkg::data_width;

  logic                        CLK;
  logic                        RST;
  logic                        start;
  logic [index_width-1:0]      size_rows;
  logic [index_width-1:0]      size_cols;
  matrix_gcd_pkg::gcd_data_t   modulus;
  logic                        in_valid;
  logic                        in_ready;
  matrix_gcd_pkg::gcd_data_t   in_a;
  matrix_gcd_pkg::gcd_data_t   in_b;
  logic                        busy;
  logic                        out_valid;
  logic                        out_ready;
  matrix_gcd_pkg::gcd_result_t out_result;

  // Headers and element triples from the golden file
  logic [15:0] golden [0:511];
  // Results still owed by the DUT, oldest first
  matrix_gcd_pkg::gcd_result_t expected_q [$];
  logic [15:0] lfsr_q = 16'd91;
  int total_elems = 0;
  int sent = 0;
  int received = 0;

  matrix_gcd_top #(
    .index_width(index_width)
  ) UUT (
    .CLK(CLK), .RST(RST), .start(start),
    .size_rows(size_rows), .size_cols(size_cols), .modulus(modulus),
    .in_valid(in_valid), .in_ready(in_ready), .in_a(in_a), .in_b(in_b),
    .busy(busy), .out_valid(out_valid), .out_ready(out_ready),
    .out_result(out_result)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci taps 16, 14, 13, 11
  function automatic logic [15:0] next_lfsr(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One step per bit drawn
  function automatic logic random_bit();
    lfsr_q = next_lfsr(lfsr_q);
    return lfsr_q[0];
  endfunction

  task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("Done: errors found");
      $fatal(1, "stopping after first mismatch");
    end
  endtask

  // 10 ns clock
  initial begin
    CLK = 1'b0;
    forever #5 CLK = ~CLK;
  end

  ////////////////////////////////////////////////////////////
  // Host side
  ////////////////////////////////////////////////////////////

  initial begin : stimulus
    int ptr;
    int jobs;
    int rows;
    int cols;
    matrix_gcd_pkg::gcd_result_t exp_r;
    RST       = 1'b1;
    start     = 1'b0;
    size_rows = '0;
    size_cols = '0;
    modulus   = '0;
    in_valid  = 1'b0;
    in_a      = '0;
    in_b      = '0;
    $readmemh("bench/matrix_gcd_golden.mem", golden);
    jobs = golden[0];
    // Walk the headers once to size the watchdog
    ptr = 1;
    for (int j = 0; j < jobs; j++) begin
      total_elems += golden[ptr] * golden[ptr+1];
      ptr += 3 + 3 * golden[ptr] * golden[ptr+1];
    end
    repeat (2) @(negedge CLK);
    RST = 1'b0;
    // Quiet until the first start
    repeat (3) begin
      @(negedge CLK);
      check_equal(32'(in_ready), 32'd0, "in_ready after reset");
      check_equal(32'(out_valid), 32'd0, "out_valid after reset");
      check_equal(32'(busy), 32'd0, "busy after reset");
    end
    ptr = 1;
    for (int j = 0; j < jobs; j++) begin
      rows = golden[ptr];
      cols = golden[ptr+1];
      start     = 1'b1;
      size_rows = index_width'(rows);
      size_cols = index_width'(cols);
      modulus   = golden[ptr+2];
      ptr += 3;
      @(negedge CLK);
      start = 1'b0;
      check_equal(32'(busy), 32'd1, "busy after start");
      for (int e = 0; e < rows * cols; e++) begin
        // Random input gaps, about one in four
        while (random_bit() & random_bit()) begin
          in_valid = 1'b0;
          @(negedge CLK);
        end
        in_valid = 1'b1;
        in_a     = golden[ptr];
        in_b     = golden[ptr+1];
        // in_ready only moves on rising edges
        while (!in_ready) @(negedge CLK);
        exp_r.value      = golden[ptr+2];
        exp_r.row_end    = ((e % cols) == cols - 1);
        exp_r.matrix_end = (e == rows * cols - 1);
        expected_q.push_back(exp_r);
        sent++;
        ptr += 3;
        @(negedge CLK);
        in_valid = 1'b0;
        // Stray start mid-job, other sizes and modulus
        if (j == 1 && e == 5) begin
          start     = 1'b1;
          size_rows = index_width'(1);
          size_cols = index_width'(1);
          modulus   = 16'h0005;
          @(negedge CLK);
          start = 1'b0;
          check_equal(32'(busy), 32'd1, "busy after ignored start");
        end
      end
      wait (received == sent);
      @(negedge CLK);
      check_equal(32'(busy), 32'd0, "busy after last result");
    end
    // No trailing result after the last job
    check_equal(32'(out_valid), 32'd0, "result after last job");
    $display("Done: no errors");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Result side
  ////////////////////////////////////////////////////////////

  initial begin : result_monitor
    matrix_gcd_pkg::gcd_result_t exp_r;
    out_ready = 1'b0;
    forever begin
      @(negedge CLK);
      // Stall about one cycle in four
      out_ready = random_bit() | random_bit();
      if (out_valid && out_ready) begin
        check_equal(32'(expected_q.size() != 0), 32'd1, "result with nothing expected");
        exp_r = expected_q.pop_front();
        check_equal(32'(out_result.value), 32'(exp_r.value), "result value");
        check_equal(32'(out_result.row_end), 32'(exp_r.row_end), "row_end flag");
        check_equal(32'(out_result.matrix_end), 32'(exp_r.matrix_end), "matrix_end flag");
        received++;
      end
    end
  end

  // Worst-case Euclid plus division per element
  initial begin : watchdog
    longint limit;
    wait (total_elems != 0);
    limit = longint'(total_elems) * ((longint'(2) << dw) + dw + 20);
    repeat (limit) @(posedge CLK);
    $display("Timeout: simulation ran past %0d cycles without finishing", limit);
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

/* bench/matrix_gcd_golden.mem */
// Word 0 is the job count. Each job: header (rows cols modulus),
// then rows*cols lines of (a b expected), all hex
0004
// Single element, no modulus
0001 0001 0000
000c 0012 0006
// 3x4, no modulus
0003 0004 0000
000c 0008 0004
0015 000e 0007
0011 0005 0001
0024 0018 000c
0000 0009 0009
0007 0000 0007
000a 000a 000a
0030 0012 0006
001b 0009 0009
0040 0030 0010
000d 001a 000d
0023 000f 0005
// 2x3, modulus 7, zero operands
0002 0003 0007
0000 0000 0000
0000 002b 0001
001e 0000 0002
003c 0028 0006
002d 001e 0001
0009 0006 0003
// 2x2, modulus 10
0002 0002 000a
0064 004b 0005
000f 0000 0005
001c 0015 0007
0090 0060 0008

/* flist.f */
source/matrix_gcd_pkg.sv
source/element_sequencer.sv
source/euclid_engine.sv
source/modulo_reducer.sv
source/matrix_gcd_top.sv
bench/matrix_gcd_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the matrix GCD testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module matrix_gcd_tb -f flist.f -o matrix_gcd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/matrix_gcd_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

echo "Simulation passed"
exit 0
